/* axi_burst_memory.sv */
/*
 * Read-only AXI4 slave backed by a small word memory.
 * One burst at a time. arready is high whenever no burst is running.
 * Beat k returns word (addr/4 + k) mod MEM_WORDS, always with OKAY.
 * Contents are loaded through the backdoor port and are not reset.
 */
`timescale 1ns/1ps

module axi_burst_memory (
    input  logic                    clk,
    input  logic                    rst_n,

    // AR channel
    input  logic                    arvalid,
    output logic                    arready,
    input  axi_read_pkg::ar_chan_t  ar,

    // R channel
    output logic                    rvalid,
    input  logic                    rready,
    output axi_read_pkg::r_chan_t   r,

    // Backdoor load
    input  logic                    mem_we,
    input  axi_read_pkg::word_idx_t mem_index,
    input  axi_read_pkg::data_t     mem_wdata
);
    import axi_read_pkg::*;

    data_t     mem [MEM_WORDS];

    logic      busy;
    word_idx_t word_idx;
    len_t      beats_left;
    id_t       burst_id;

    assign arready = !busy;
    assign rvalid  = busy;

    always_comb begin
        r.data = mem[word_idx];
        r.resp = RESP_OKAY;
        r.last = (beats_left == '0);
        r.id   = burst_id;
    end

    ////////////////////////////////////////
    // Burst control
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (!busy) begin
            if (arvalid) begin
                busy <= 1'b1;
            end
        end else if (rready && r.last) begin
            busy <= 1'b0;
        end
    end

    // Beat position and request fields
    always_ff @(posedge clk) begin
        if (!busy && arvalid) begin
            // Byte address to word index, upper bits wrap away
            word_idx   <= ar.addr[5:2];
            beats_left <= ar.len;
            burst_id   <= ar.id;
        end else if (busy && rready) begin
            word_idx   <= word_idx + word_idx_t'(1);
            beats_left <= beats_left - len_t'(1);
        end
    end

    ////////////////////////////////////////
    // Backdoor write
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[mem_index] <= mem_wdata;
        end
    end

endmodule

/* axi_read_cases.txt */
# C region field value     region table write, region and value in hex
# M client index data      memory backdoor write, all in hex
# R name addr len id resp  read test, addr len id in hex, resp is OKAY or DECERR
C 0 BASE 0000
C 0 END 0100
C 0 CLIENT_BASE 0000
C 0 CLIENT_VALID 8000
C 1 BASE 1000
C 1 END 1040
C 1 CLIENT_BASE 1000
C 1 CLIENT_VALID 8001
C 2 BASE 0080
C 2 END 00c0
C 2 CLIENT_BASE 0040
C 2 CLIENT_VALID 8001
M 0 3 deadbeef
M 1 5 12345678
M 1 2 cafe0002
R rd_client0 000c 1 3 OKAY
R rd_client1 1014 2 5 OKAY
R miss_far 2000 3 9 DECERR
R overlap_hi 0088 0 a OKAY
R wrap_long 0030 13 1 OKAY
R miss_long 5000 f 2 DECERR
C 1 END 1020
R shrunk_miss 1024 0 4 DECERR
R shrunk_hit 101c 1 4 OKAY
C 0 CLIENT_VALID 0000
R cleared 0010 2 6 DECERR
R overlap_only 0090 1 7 OKAY
C 0 CLIENT_VALID 8001
R moved 0008 0 8 OKAY
R stall_long 1000 1f c OKAY

/* axi_read_checker.sv */
/*
 * Assertions on the upstream read channel and the downstream AR fan-out.
 * Bound into axi_read_subsystem.
 * Assumes reset is held low for at least two rising edges.
 */
`timescale 1ns/1ps

module axi_read_checker (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  up_rvalid,
    input logic                  up_rready,
    input axi_read_pkg::r_chan_t up_r,
    input logic                  dn_arvalid [axi_read_pkg::NUM_CLIENTS],
    input logic                  dn_arready [axi_read_pkg::NUM_CLIENTS]
);
    import axi_read_pkg::*;

    logic [NUM_CLIENTS-1:0] arvalid_vec;
    logic [NUM_CLIENTS-1:0] arready_vec;
    int                     assert_fails = 0;

    always_comb begin
        for (int i = 0; i < NUM_CLIENTS; i++) begin
            arvalid_vec[i] = dn_arvalid[i];
            arready_vec[i] = dn_arready[i];
        end
    end

    // A stalled beat keeps valid and payload until it is taken
    rvalid_held: assert property (@(posedge clk) disable iff (!rst_n)
        up_rvalid && !up_rready |=> up_rvalid && $stable(up_r))
    else begin
        assert_fails++;
        $error("up_r changed or up_rvalid dropped while the beat was stalled");
    end

    // At most one client sees an address request, and a stalled one stays raised
    arvalid_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(arvalid_vec)
        && (($past(arvalid_vec & ~arready_vec) & ~arvalid_vec) == '0))
    else begin
        assert_fails++;
        $error("dn_arvalid is not one-hot or dropped before it was accepted");
    end

    // Router state is defined from the second reset edge on
    rvalid_reset: assert property (@(posedge clk)
        !rst_n |=> (rst_n || !up_rvalid))
    else begin
        assert_fails++;
        $error("up_rvalid is high during reset");
    end

endmodule

bind axi_read_subsystem axi_read_checker read_chk (
    .clk       (clk),
    .rst_n     (rst_n),
    .up_rvalid (up_rvalid),
    .up_rready (up_rready),
    .up_r      (up_r),
    .dn_arvalid(dn_arvalid),
    .dn_arready(dn_arready)
);

/* axi_read_pkg.sv */
/*
 * Shared types for the AXI4 read-side interconnect.
 * Only the AR and R channels exist. Every burst is INCR with 4-byte beats.
 * Client and region counts are fixed here. The RTL has no module parameters.
 */
package axi_read_pkg;

    ////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////
    localparam int NUM_CLIENTS  = 2;
    localparam int REGION_COUNT = 4;
    localparam int MEM_WORDS    = 16;

    // Widths that carry a meaning
    typedef logic [15:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  id_t;
    typedef logic [7:0]  len_t;
    typedef logic [1:0]  resp_t;
    typedef logic [0:0]  client_t;
    typedef logic [1:0]  region_idx_t;
    typedef logic [3:0]  word_idx_t;

    // AXI response codes
    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_DECERR = 2'b11;

    ////////////////////////////////////////
    // Channel payloads
    ////////////////////////////////////////
    typedef struct packed {
        addr_t      addr;
        len_t       len;
        logic [2:0] size;
        logic [1:0] burst;
        id_t        id;
        logic       lock;
        logic [2:0] prot;
    } ar_chan_t;

    typedef struct packed {
        data_t data;
        resp_t resp;
        logic  last;
        id_t   id;
    } r_chan_t;

    // One address window, end_addr is exclusive
    typedef struct packed {
        logic    valid;
        addr_t   base;
        addr_t   end_addr;
        client_t client;
        addr_t   client_base;
    } region_t;

    typedef enum logic [1:0] {BASE, END, CLIENT_BASE, CLIENT_VALID} region_field_t;

    typedef enum logic [1:0] {IDLE, ACTIVE, DECERR} router_state_t;

endpackage

/* axi_read_router.sv */
/*
 * 1-to-N AXI4 read router, one transaction in flight at a time.
 * The region table decides the client. A miss is answered locally with
 * arlen+1 DECERR beats carrying zero data and the request id.
 * A routed read leaves IDLE one cycle before its AR is forwarded.
 * arsize, arburst, arlock and arprot pass through untouched.
 */
`timescale 1ns/1ps

module axi_read_router (
    input  logic                   clk,
    input  logic                   rst_n,

    // Upstream master side
    input  logic                   up_arvalid,
    output logic                   up_arready,
    input  axi_read_pkg::ar_chan_t up_ar,
    output logic                   up_rvalid,
    input  logic                   up_rready,
    output axi_read_pkg::r_chan_t  up_r,

    // Region table lookup
    output axi_read_pkg::addr_t    lookup_addr,
    input  logic                   hit,
    input  axi_read_pkg::client_t  hit_client,
    input  axi_read_pkg::addr_t    hit_offset,

    // Downstream client side
    output logic                   dn_arvalid [axi_read_pkg::NUM_CLIENTS],
    input  logic                   dn_arready [axi_read_pkg::NUM_CLIENTS],
    output axi_read_pkg::ar_chan_t dn_ar,
    input  logic                   dn_rvalid  [axi_read_pkg::NUM_CLIENTS],
    output logic                   dn_rready  [axi_read_pkg::NUM_CLIENTS],
    input  axi_read_pkg::r_chan_t  dn_r       [axi_read_pkg::NUM_CLIENTS]
);
    import axi_read_pkg::*;

    router_state_t state, state_nxt;
    client_t       client_sel, client_nxt;
    logic          ardone, ardone_nxt;
    logic          rdone, rdone_nxt;

    // Request payload kept for the routed or DECERR transaction
    addr_t         raddr, raddr_nxt;
    id_t           rid, rid_nxt;
    len_t          rlen, rlen_nxt;

    assign lookup_addr = up_ar.addr;

    // Only the address is rewritten on the way down
    always_comb begin
        dn_ar      = up_ar;
        dn_ar.addr = raddr;
    end

    ////////////////////////////////////////
    // Control and channel muxing
    ////////////////////////////////////////
    always_comb begin
        state_nxt  = state;
        client_nxt = client_sel;
        ardone_nxt = ardone;
        rdone_nxt  = rdone;
        raddr_nxt  = raddr;
        rid_nxt    = rid;
        rlen_nxt   = rlen;

        up_arready = 1'b0;
        up_rvalid  = 1'b0;
        up_r       = dn_r[client_sel];
        for (int i = 0; i < NUM_CLIENTS; i++) begin
            dn_arvalid[i] = 1'b0;
            dn_rready[i]  = 1'b0;
        end

        case (state)
            IDLE: begin
                if (up_arvalid) begin
                    if (hit) begin
                        client_nxt = hit_client;
                        raddr_nxt  = hit_offset;
                        state_nxt  = ACTIVE;
                    end else begin
                        // Nobody owns this address, accept and answer locally
                        up_arready = 1'b1;
                        rlen_nxt   = up_ar.len;
                        rid_nxt    = up_ar.id;
                        state_nxt  = DECERR;
                    end
                end
            end

            ACTIVE: begin
                // AR handshake
                dn_arvalid[client_sel] = up_arvalid && !ardone;
                up_arready = dn_arready[client_sel] && !ardone;
                if (up_arvalid && up_arready) begin
                    ardone_nxt = 1'b1;
                end

                // R handshake, back-pressure goes straight down
                dn_rready[client_sel] = up_rready && !rdone;
                up_rvalid = dn_rvalid[client_sel] && !rdone;
                if (up_rvalid && up_rready && up_r.last) begin
                    rdone_nxt = 1'b1;
                end

                if (ardone_nxt && rdone_nxt) begin
                    state_nxt  = IDLE;
                    ardone_nxt = 1'b0;
                    rdone_nxt  = 1'b0;
                end
            end

            DECERR: begin
                up_rvalid   = 1'b1;
                up_r        = '0;
                up_r.resp   = RESP_DECERR;
                up_r.last   = (rlen == '0);
                up_r.id     = rid;
                if (up_rready) begin
                    rlen_nxt = rlen - len_t'(1);
                    if (rlen == '0) begin
                        state_nxt = IDLE;
                    end
                end
            end

            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    ////////////////////////////////////////
    // Registers
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= IDLE;
            client_sel <= '0;
            ardone     <= 1'b0;
            rdone      <= 1'b0;
        end else begin
            state      <= state_nxt;
            client_sel <= client_nxt;
            ardone     <= ardone_nxt;
            rdone      <= rdone_nxt;
        end
    end

    always_ff @(posedge clk) begin
        raddr <= raddr_nxt;
        rid   <= rid_nxt;
        rlen  <= rlen_nxt;
    end

endmodule

/* axi_read_subsystem.sv */
/*
 * Read subsystem top level: one upstream AR/R port, a region table,
 * the router and two 16-word memory clients (client 0 and client 1).
 * The backdoor write goes to the memory picked by mem_client.
 */
`timescale 1ns/1ps

module axi_read_subsystem (
    input  logic                        clk,
    input  logic                        rst_n,

    input  logic                        up_arvalid,
    output logic                        up_arready,
    input  axi_read_pkg::ar_chan_t      up_ar,
    output logic                        up_rvalid,
    input  logic                        up_rready,
    output axi_read_pkg::r_chan_t       up_r,

    input  logic                        cfg_we,
    input  axi_read_pkg::region_idx_t   cfg_region,
    input  axi_read_pkg::region_field_t cfg_field,
    input  axi_read_pkg::addr_t         cfg_wdata,

    input  logic                        mem_we,
    input  axi_read_pkg::client_t       mem_client,
    input  axi_read_pkg::word_idx_t     mem_index,
    input  axi_read_pkg::data_t         mem_wdata
);
    import axi_read_pkg::*;

    addr_t    lookup_addr;
    logic     hit;
    client_t  hit_client;
    addr_t    hit_offset;

    logic     dn_arvalid [NUM_CLIENTS];
    logic     dn_arready [NUM_CLIENTS];
    ar_chan_t dn_ar;
    logic     dn_rvalid  [NUM_CLIENTS];
    logic     dn_rready  [NUM_CLIENTS];
    r_chan_t  dn_r       [NUM_CLIENTS];

    logic     mem_we_sel [NUM_CLIENTS];

    // Backdoor strobe per client
    assign mem_we_sel[0] = mem_we && (mem_client == client_t'(0));
    assign mem_we_sel[1] = mem_we && (mem_client == client_t'(1));

    axi_region_table regions (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg_we     (cfg_we),
        .cfg_region (cfg_region),
        .cfg_field  (cfg_field),
        .cfg_wdata  (cfg_wdata),
        .lookup_addr(lookup_addr),
        .hit        (hit),
        .hit_client (hit_client),
        .hit_offset (hit_offset)
    );

    axi_read_router router (
        .clk        (clk),
        .rst_n      (rst_n),
        .up_arvalid (up_arvalid),
        .up_arready (up_arready),
        .up_ar      (up_ar),
        .up_rvalid  (up_rvalid),
        .up_rready  (up_rready),
        .up_r       (up_r),
        .lookup_addr(lookup_addr),
        .hit        (hit),
        .hit_client (hit_client),
        .hit_offset (hit_offset),
        .dn_arvalid (dn_arvalid),
        .dn_arready (dn_arready),
        .dn_ar      (dn_ar),
        .dn_rvalid  (dn_rvalid),
        .dn_rready  (dn_rready),
        .dn_r       (dn_r)
    );

    ////////////////////////////////////////
    // Memory clients
    ////////////////////////////////////////
    axi_burst_memory mem0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .arvalid  (dn_arvalid[0]),
        .arready  (dn_arready[0]),
        .ar       (dn_ar),
        .rvalid   (dn_rvalid[0]),
        .rready   (dn_rready[0]),
        .r        (dn_r[0]),
        .mem_we   (mem_we_sel[0]),
        .mem_index(mem_index),
        .mem_wdata(mem_wdata)
    );

    axi_burst_memory mem1 (
        .clk      (clk),
        .rst_n    (rst_n),
        .arvalid  (dn_arvalid[1]),
        .arready  (dn_arready[1]),
        .ar       (dn_ar),
        .rvalid   (dn_rvalid[1]),
        .rready   (dn_rready[1]),
        .r        (dn_r[1]),
        .mem_we   (mem_we_sel[1]),
        .mem_index(mem_index),
        .mem_wdata(mem_wdata)
    );

endmodule

/* axi_region_table.sv */
/*
 * Programmable region table for the read router.
 * Fields are written one at a time. A CLIENT_VALID write takes bit 0 as the
 * client number and bit 15 as the valid flag.
 * Lookup is combinational and the highest-numbered matching region wins.
 * Reset clears only the valid flags, so a region must be fully rewritten.
 */
`timescale 1ns/1ps

module axi_region_table (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        cfg_we,
    input  axi_read_pkg::region_idx_t   cfg_region,
    input  axi_read_pkg::region_field_t cfg_field,
    input  axi_read_pkg::addr_t         cfg_wdata,
    input  axi_read_pkg::addr_t         lookup_addr,
    output logic                        hit,
    output axi_read_pkg::client_t       hit_client,
    output axi_read_pkg::addr_t         hit_offset
);
    import axi_read_pkg::*;

    region_t regions [REGION_COUNT];

    ////////////////////////////////////////
    // Configuration writes
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < REGION_COUNT; i++) begin
                regions[i].valid <= 1'b0;
            end
        end else if (cfg_we) begin
            case (cfg_field)
                BASE: begin
                    regions[cfg_region].base <= cfg_wdata;
                end
                END: begin
                    regions[cfg_region].end_addr <= cfg_wdata;
                end
                CLIENT_BASE: begin
                    regions[cfg_region].client_base <= cfg_wdata;
                end
                CLIENT_VALID: begin
                    regions[cfg_region].client <= cfg_wdata[0];
                    regions[cfg_region].valid  <= cfg_wdata[15];
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////
    // Ascending scan, so a later match overrides an earlier one
    always_comb begin
        hit        = 1'b0;
        hit_client = '0;
        hit_offset = lookup_addr;
        for (int i = 0; i < REGION_COUNT; i++) begin
            if (regions[i].valid
                    && lookup_addr >= regions[i].base
                    && lookup_addr < regions[i].end_addr) begin
                hit        = 1'b1;
                hit_client = regions[i].client;
                // Rebase into the client's own address space
                hit_offset = lookup_addr - regions[i].client_base;
            end
        end
    end

endmodule

/* sim.f */
axi_read_pkg.sv
axi_region_table.sv
axi_read_router.sv
axi_burst_memory.sv
axi_read_subsystem.sv
axi_read_checker.sv
tb_axi_read_subsystem.sv

/* tb_axi_read_subsystem.sv */
/*
 * Testbench for the AXI4 read subsystem.
 * Replays axi_read_cases.txt from the project root: region writes, memory
 * writes and read tests. Expected beats come from a model of the region
 * table and of both memories. Memories are first filled with a pattern
 * that depends on client and word index. up_rready drops on random cycles.
 */
`timescale 1ns/1ps

module tb_axi_read_subsystem;
    import axi_read_pkg::*;

    localparam int CYCLES_PER_CASE = 200;

    typedef logic [8*16-1:0] name_t;

    // One parsed line of the case file
    typedef struct packed {
        logic [7:0]    kind;
        name_t         name;
        region_idx_t   region;
        region_field_t field;
        client_t       client;
        word_idx_t     index;
        addr_t         addr;
        data_t         data;
        len_t          len;
        id_t           id;
        resp_t         resp;
    } case_t;

    logic          clk;
    logic          rst_n;
    logic          up_arvalid;
    logic          up_arready;
    ar_chan_t      up_ar;
    logic          up_rvalid;
    logic          up_rready;
    r_chan_t       up_r;
    logic          cfg_we;
    region_idx_t   cfg_region;
    region_field_t cfg_field;
    addr_t         cfg_wdata;
    logic          mem_we;
    client_t       mem_client;
    word_idx_t     mem_index;
    data_t         mem_wdata;

    // Reference model of the table and the memories
    region_t       model_regions [REGION_COUNT];
    data_t         model_mem [NUM_CLIENTS][MEM_WORDS];

    case_t         cases [$];
    int            seed;
    int            err_count;
    int            tests_run;
    int            tests_failed;
    int            assert_fails;
    int            cycle_limit;
    logic          cases_loaded;

    axi_read_subsystem uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .up_arvalid(up_arvalid),
        .up_arready(up_arready),
        .up_ar     (up_ar),
        .up_rvalid (up_rvalid),
        .up_rready (up_rready),
        .up_r      (up_r),
        .cfg_we    (cfg_we),
        .cfg_region(cfg_region),
        .cfg_field (cfg_field),
        .cfg_wdata (cfg_wdata),
        .mem_we    (mem_we),
        .mem_client(mem_client),
        .mem_index (mem_index),
        .mem_wdata (mem_wdata)
    );

    always #5 clk = ~clk;

    ////////////////////////////////////////
    // Model helpers
    ////////////////////////////////////////
    function automatic data_t fill_word(input client_t c, input word_idx_t idx);
        return {12'hF11, 3'b000, c, 12'h000, idx};
    endfunction

    // Highest-numbered valid region containing the address wins
    function automatic logic route_lookup(input addr_t a, output client_t cl,
                                          output addr_t off);
        logic found;
        found = 1'b0;
        cl    = '0;
        off   = a;
        for (int i = REGION_COUNT - 1; i >= 0; i--) begin
            if (!found && model_regions[i].valid
                    && a >= model_regions[i].base && a < model_regions[i].end_addr) begin
                found = 1'b1;
                cl    = model_regions[i].client;
                off   = a - model_regions[i].client_base;
            end
        end
        return found;
    endfunction

    ////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////
    task automatic check_r(input name_t name, input int beat, input r_chan_t exp,
                           input r_chan_t act);
        if (act !== exp) begin
            err_count++;
            $display("error %0s beat %0d: expected %h/%0d/%0b/%h actual %h/%0d/%0b/%h",
                     name, beat, exp.data, exp.resp, exp.last, exp.id,
                     act.data, act.resp, act.last, act.id);
        end
    endtask

    task automatic check_beats(input name_t name, input len_t exp, input len_t act);
        if (act !== exp) begin
            err_count++;
            $display("error %0s burst length: expected len %0d actual len %0d",
                     name, exp, act);
        end
    endtask

    ////////////////////////////////////////
    // Case file
    ////////////////////////////////////////
    task automatic load_cases();
        int               fd;
        int               n;
        logic [8*16-1:0]  tok;
        logic [8*16-1:0]  field_tok;
        logic [8*16-1:0]  resp_tok;
        logic [8*128-1:0] rest;
        region_idx_t      region_v;
        client_t          client_v;
        word_idx_t        index_v;
        addr_t            addr_v;
        data_t            data_v;
        len_t             len_v;
        id_t              id_v;
        name_t            name_v;
        case_t            rec;
        logic             done;
        fd = $fopen("axi_read_cases.txt", "r");
        if (fd == 0) begin
            err_count++;
            $display("could not open axi_read_cases.txt");
        end else begin
            done = 1'b0;
            while (!done) begin
                rec = '0;
                n   = $fscanf(fd, "%s", tok);
                if (n != 1) begin
                    done = 1'b1;
                end else if (tok == "#") begin
                    n = $fgets(rest, fd);
                end else if (tok == "C") begin
                    n = $fscanf(fd, "%h %s %h", region_v, field_tok, addr_v);
                    rec.kind   = "C";
                    rec.region = region_v;
                    rec.addr   = addr_v;
                    case (field_tok)
                        "BASE":         rec.field = BASE;
                        "END":          rec.field = END;
                        "CLIENT_BASE":  rec.field = CLIENT_BASE;
                        "CLIENT_VALID": rec.field = CLIENT_VALID;
                        default: begin
                            n = 0;
                        end
                    endcase
                    if (n != 3) begin
                        err_count++;
                        $display("bad region line in case file");
                    end else begin
                        cases.push_back(rec);
                    end
                end else if (tok == "M") begin
                    n = $fscanf(fd, "%h %h %h", client_v, index_v, data_v);
                    rec.kind   = "M";
                    rec.client = client_v;
                    rec.index  = index_v;
                    rec.data   = data_v;
                    if (n != 3) begin
                        err_count++;
                        $display("bad memory line in case file");
                    end else begin
                        cases.push_back(rec);
                    end
                end else if (tok == "R") begin
                    n = $fscanf(fd, "%s %h %h %h %s", name_v, addr_v, len_v, id_v, resp_tok);
                    rec.kind = "R";
                    rec.name = name_v;
                    rec.addr = addr_v;
                    rec.len  = len_v;
                    rec.id   = id_v;
                    rec.resp = (resp_tok == "DECERR") ? RESP_DECERR : RESP_OKAY;
                    if (n != 5) begin
                        err_count++;
                        $display("bad read line in case file");
                    end else begin
                        cases.push_back(rec);
                    end
                end else begin
                    err_count++;
                    $display("unknown line kind in case file");
                    done = 1'b1;
                end
            end
            $fclose(fd);
        end
    endtask

    ////////////////////////////////////////
    // Drivers
    ////////////////////////////////////////
    task automatic write_region(input region_idx_t region, input region_field_t field,
                                input addr_t value);
        @(negedge clk);
        cfg_we     = 1'b1;
        cfg_region = region;
        cfg_field  = field;
        cfg_wdata  = value;
        @(negedge clk);
        cfg_we = 1'b0;
        case (field)
            BASE: begin
                model_regions[region].base = value;
            end
            END: begin
                model_regions[region].end_addr = value;
            end
            CLIENT_BASE: begin
                model_regions[region].client_base = value;
            end
            default: begin
                model_regions[region].client = value[0];
                model_regions[region].valid  = value[15];
            end
        endcase
    endtask

    task automatic write_mem(input client_t c, input word_idx_t idx, input data_t d);
        @(negedge clk);
        mem_we     = 1'b1;
        mem_client = c;
        mem_index  = idx;
        mem_wdata  = d;
        @(negedge clk);
        mem_we = 1'b0;
        model_mem[c][idx] = d;
    endtask

    task automatic run_read(input case_t c);
        r_chan_t exp_beats [$];
        r_chan_t beat;
        logic    hit_m;
        client_t cl;
        addr_t   off;
        int      beats;
        int      errs_before;
        logic    ar_done;
        logic    r_done;
        errs_before = err_count;
        hit_m = route_lookup(c.addr, cl, off);
        if ((hit_m ? RESP_OKAY : RESP_DECERR) != c.resp) begin
            err_count++;
            $display("case %0s expects a response that the region model does not give",
                     c.name);
        end
        // Predict every beat, word index wraps at 16
        for (int k = 0; k <= int'(c.len); k++) begin
            beat      = '0;
            beat.id   = c.id;
            beat.last = (k == int'(c.len));
            if (hit_m) begin
                beat.data = model_mem[cl][word_idx_t'((off >> 2) + k)];
                beat.resp = RESP_OKAY;
            end else begin
                beat.resp = RESP_DECERR;
            end
            exp_beats.push_back(beat);
        end

        up_ar       = '0;
        up_ar.addr  = c.addr;
        up_ar.len   = c.len;
        up_ar.size  = 3'b010;
        up_ar.burst = 2'b01;
        up_ar.id    = c.id;
        ar_done     = 1'b0;
        r_done      = 1'b0;
        beats       = 0;
        while (!(ar_done && r_done)) begin
            @(negedge clk);
            up_arvalid = !ar_done;
            up_rready  = ({$random(seed)} % 4) != 0;
            // Sample once the inputs of this cycle have settled
            #1;
            if (up_arvalid && up_arready) begin
                ar_done = 1'b1;
            end
            if (up_rvalid && up_rready) begin
                if (beats < exp_beats.size()) begin
                    check_r(c.name, beats, exp_beats[beats], up_r);
                end else if (beats == exp_beats.size()) begin
                    err_count++;
                    $display("%0s returned more beats than its len asks for", c.name);
                end
                beats++;
                if (up_r.last) begin
                    r_done = 1'b1;
                end
            end
        end
        @(negedge clk);
        up_arvalid = 1'b0;
        up_rready  = 1'b0;

        check_beats(c.name, c.len, len_t'(beats - 1));
        tests_run++;
        if (err_count == errs_before) begin
            $display("%0s: ok, %0d beats", c.name, beats);
        end else begin
            tests_failed++;
            $display("%0s: failed, %0d beats", c.name, beats);
        end
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////
    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        up_arvalid   = 1'b0;
        up_ar        = '0;
        up_rready    = 1'b0;
        cfg_we       = 1'b0;
        cfg_region   = '0;
        cfg_field    = BASE;
        cfg_wdata    = '0;
        mem_we       = 1'b0;
        mem_client   = '0;
        mem_index    = '0;
        mem_wdata    = '0;
        seed         = 62;
        err_count    = 0;
        tests_run    = 0;
        tests_failed = 0;
        cases_loaded = 1'b0;
        for (int i = 0; i < REGION_COUNT; i++) begin
            model_regions[i] = '0;
        end

        load_cases();
        cases_loaded = 1'b1;

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int c = 0; c < NUM_CLIENTS; c++) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                write_mem(client_t'(c), word_idx_t'(i), fill_word(client_t'(c), word_idx_t'(i)));
            end
        end

        foreach (cases[i]) begin
            if (cases[i].kind == "C") begin
                write_region(cases[i].region, cases[i].field, cases[i].addr);
            end else if (cases[i].kind == "M") begin
                write_mem(cases[i].client, cases[i].index, cases[i].data);
            end else begin
                run_read(cases[i]);
            end
        end

        assert_fails = uut.read_chk.assert_fails;
        err_count    = err_count + assert_fails;
        $display("tests %0d, passed %0d, failed %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_run - tests_failed, tests_failed, err_count, assert_fails);
        if (err_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // Watchdog, sized from the number of case lines
    initial begin
        wait (cases_loaded);
        cycle_limit = (cases.size() + 1) * CYCLES_PER_CASE;
        repeat (cycle_limit) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule
